// ==== vmem_cfg.svh ====
`ifndef VMEM_CFG_SVH
`define VMEM_CFG_SVH

// Data and address width of the stage
`define VMEM_XLEN 32

// Number of words in the data cache model
`define VMEM_DEPTH 64

// Cycles a request is held before dhit rises
`define VMEM_HIT_LATENCY 2

// Largest vl a configuration instruction may set
`define VMEM_VLMAX 8

`endif

// ==== vmem_pkg.sv ====
`default_nettype none

`include "vmem_cfg.svh"

package vmem_pkg;

  // Plain vectors with a meaning
  typedef logic [`VMEM_XLEN-1:0] word_t;
  typedef logic [7:0]            elem_idx_t;
  typedef logic [3:0]            byte_ena_t;
  typedef logic [4:0]            vreg_t;

  // Element width, straight from vtype[2:0]
  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2
  } sew_t;

  // Kind of configuration instruction, if any
  typedef enum logic [1:0] {
    NOT_CFG     = 2'd0,
    CFG_VSETVLI = 2'd1,
    CFG_VSETVL  = 2'd2
  } cfg_t;

  // Address scheduler FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LANE0 = 2'd1,
    LANE1 = 2'd2,
    DONE  = 2'd3
  } sched_state_t;

  // Execute to memory bundle
  typedef struct packed {
    logic      load;
    logic      store;
    word_t     aluresult0;
    word_t     aluresult1;
    word_t     storedata0;
    word_t     storedata1;
    logic      wen0;
    logic      wen1;
    elem_idx_t woffset0;
    elem_idx_t woffset1;
    vreg_t     vd;
    logic      rd_wen;
    vreg_t     rd_sel;
    word_t     rd_data;
    cfg_t      config_type;
    word_t     next_vtype;
    word_t     next_avl;
  } ex_mem_t;

  // Memory to writeback bundle
  typedef struct packed {
    word_t     wdat0;
    word_t     wdat1;
    logic      wen0;
    logic      wen1;
    elem_idx_t woffset0;
    elem_idx_t woffset1;
    vreg_t     vd;
    logic      rd_wen;
    vreg_t     rd_sel;
    word_t     rd_data;
    sew_t      sew;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== vmem_addr_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmem_addr_scheduler
  import vmem_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      load,
  input  logic      store,
  input  word_t     addr0,
  input  word_t     addr1,
  input  word_t     storedata0,
  input  word_t     storedata1,
  input  elem_idx_t woffset1,
  input  word_t     vl,
  input  sew_t      sew,
  input  logic      dhit,
  input  logic      returnex,
  output word_t     final_addr,
  output word_t     final_storedata,
  output logic      ren,
  output logic      wen,
  output byte_ena_t byte_ena,
  output logic      arrived0,
  output logic      arrived1,
  output logic      busy,
  output logic      exception
);

  sched_state_t state, next_state;
  logic         mem_op;
  logic         lane1_active;
  logic         misaligned;
  logic         lane_req;
  word_t        cur_addr;
  word_t        cur_store;

  // Element must start on a multiple of its own size
  function automatic logic is_misaligned(input word_t a, input sew_t s);
    case (s)
      SEW16:   return a[0];
      SEW32:   return |a[1:0];
      default: return 1'b0;
    endcase
  endfunction

  assign mem_op       = load | store;
  // Lane 1 only when its element index falls inside vl
  assign lane1_active = word_t'(woffset1) < vl;
  assign misaligned   = mem_op &&
                        (is_misaligned(addr0, sew) ||
                         (lane1_active && is_misaligned(addr1, sew)));

  // State register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Walk the active lanes, one access each
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (mem_op) begin
          // Bad alignment skips all accesses
          next_state = misaligned ? DONE : LANE0;
        end
      end
      LANE0: begin
        if (dhit) begin
          next_state = lane1_active ? LANE1 : DONE;
        end
      end
      LANE1: begin
        if (dhit) begin
          next_state = DONE;
        end
      end
      DONE: begin
        // Wait here until the latch takes the instruction
        if (returnex) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // Request held level in either lane state
  assign lane_req  = (state == LANE0) || (state == LANE1);
  assign cur_addr  = (state == LANE1) ? addr1 : addr0;
  assign cur_store = (state == LANE1) ? storedata1 : storedata0;

  assign final_addr = cur_addr;
  assign ren        = load && lane_req;
  assign wen        = store && lane_req;

  // Byte lanes picked by the low address bits
  always_comb begin
    case (sew)
      SEW8:    byte_ena = 4'b0001 << cur_addr[1:0];
      SEW16:   byte_ena = cur_addr[1] ? 4'b1100 : 4'b0011;
      default: byte_ena = 4'b1111;
    endcase
  end

  // Aligned element, so one byte shift covers every width
  assign final_storedata = cur_store << {cur_addr[1:0], 3'b000};

  // Data for a lane is on the bus in its dhit cycle
  assign arrived0  = load && (state == LANE0) && dhit;
  assign arrived1  = load && (state == LANE1) && dhit;
  assign busy      = mem_op && (state != DONE);
  assign exception = (state == IDLE) && misaligned;

  // Load and store share one request path
  assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen));

endmodule

`default_nettype wire

// ==== vmem_dcache_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vmem_cfg.svh"

module vmem_dcache_model
  import vmem_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  word_t     addr,
  input  word_t     wdata,
  input  logic      ren,
  input  logic      wen,
  input  byte_ena_t byte_ena,
  output word_t     rdata,
  output logic      dhit
);

  localparam int AW = $clog2(`VMEM_DEPTH);
  localparam int CW = $clog2(`VMEM_HIT_LATENCY + 1);

  word_t         mem [`VMEM_DEPTH];
  logic [AW-1:0] idx;
  logic [CW-1:0] wait_cnt;
  logic          req;

  // Word index, byte offset dropped
  assign idx = addr[AW+1:2];
  assign req = ren | wen;

  // Hit on the last cycle of the hold time
  assign dhit  = req && (wait_cnt == CW'(`VMEM_HIT_LATENCY));
  assign rdata = mem[idx];

  // Hold-time counter, restarts after each hit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!req || dhit) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Preload pattern on reset, byte merge on write hit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `VMEM_DEPTH; i++) begin
        mem[i] <= 32'h1000_0000 + word_t'(i);
      end
    end else if (wen && dhit) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_ena[b]) begin
          mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // A write must touch at least one byte
  assert property (@(posedge CLK) disable iff (!nRST) wen |-> (byte_ena != '0));

endmodule

`default_nettype wire

// ==== vmem_csr_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vmem_cfg.svh"

module vmem_csr_block
  import vmem_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  cfg_t  config_type,
  input  word_t next_avl,
  input  word_t next_vtype,
  input  logic  advance,
  output word_t vl,
  output word_t vtype,
  output sew_t  sew,
  output word_t new_vl
);

  logic cfg_write;

  // Requested length capped at VLMAX
  always_comb begin
    if (next_avl > word_t'(`VMEM_VLMAX)) begin
      new_vl = word_t'(`VMEM_VLMAX);
    end else begin
      new_vl = next_avl;
    end
  end

  // Only when the config instruction leaves the stage
  assign cfg_write = (config_type != NOT_CFG) && advance;

  // vl and vtype registers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl    <= '0;
      vtype <= '0;
    end else if (cfg_write) begin
      vl    <= new_vl;
      vtype <= next_vtype;
    end
  end

  // Element width field of vtype
  assign sew = sew_t'(vtype[2:0]);

endmodule

`default_nettype wire

// ==== vmem_memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmem_memory_stage
  import vmem_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  ex_mem_t   ex,
  input  logic      stall_mem,
  input  logic      flush_mem,
  input  word_t     dmemload,
  input  logic      dhit,
  output word_t     dmemaddr,
  output word_t     dmemstore,
  output logic      ren,
  output logic      wen,
  output byte_ena_t byte_ena,
  output mem_wb_t   wb,
  output logic      busy_mem,
  output logic      exception_mem,
  output logic      csr_update,
  output word_t     vl,
  output word_t     vtype
);

  logic    arrived0;
  logic    arrived1;
  logic    sched_busy;
  logic    adv;
  logic    csr_adv;
  sew_t    sew;
  word_t   new_vl;
  word_t   load_elem;
  word_t   shifted;
  word_t   buf0;
  word_t   buf1;
  logic    buf1_vld;
  mem_wb_t next_wb;

  // Latch moves when nothing holds it back
  assign adv     = !stall_mem && !sched_busy;
  assign csr_adv = adv && !flush_mem;

  vmem_addr_scheduler sched0 (
    .CLK             (CLK),
    .nRST            (nRST),
    .load            (ex.load),
    .store           (ex.store),
    .addr0           (ex.aluresult0),
    .addr1           (ex.aluresult1),
    .storedata0      (ex.storedata0),
    .storedata1      (ex.storedata1),
    .woffset1        (ex.woffset1),
    .vl              (vl),
    .sew             (sew),
    .dhit            (dhit),
    .returnex        (adv),
    .final_addr      (dmemaddr),
    .final_storedata (dmemstore),
    .ren             (ren),
    .wen             (wen),
    .byte_ena        (byte_ena),
    .arrived0        (arrived0),
    .arrived1        (arrived1),
    .busy            (sched_busy),
    .exception       (exception_mem)
  );

  vmem_csr_block csr0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .config_type (ex.config_type),
    .next_avl    (ex.next_avl),
    .next_vtype  (ex.next_vtype),
    .advance     (csr_adv),
    .vl          (vl),
    .vtype       (vtype),
    .sew         (sew),
    .new_vl      (new_vl)
  );

  assign busy_mem   = sched_busy;
  assign csr_update = ex.config_type != NOT_CFG;

  // Element moved down to bit 0, upper bits zero
  assign shifted = dmemload >> {dmemaddr[1:0], 3'b000};
  always_comb begin
    case (sew)
      SEW8:    load_elem = {24'd0, shifted[7:0]};
      SEW16:   load_elem = {16'd0, shifted[15:0]};
      default: load_elem = shifted;
    endcase
  end

  // Load buffer data, one entry per lane
  always_ff @(posedge CLK) begin
    if (arrived0) begin
      buf0 <= load_elem;
    end
    if (arrived1) begin
      buf1 <= load_elem;
    end
  end

  // Lane 1 entry valid until the instruction leaves
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      buf1_vld <= 1'b0;
    end else if (arrived1) begin
      buf1_vld <= 1'b1;
    end else if (adv) begin
      buf1_vld <= 1'b0;
    end
  end

  // Writeback values
  always_comb begin
    next_wb          = '0;
    next_wb.wdat0    = ex.load ? buf0 : ex.aluresult0;
    // Inactive lane 1 passes the ALU result
    next_wb.wdat1    = (ex.load && buf1_vld) ? buf1 : ex.aluresult1;
    next_wb.wen0     = ex.wen0;
    next_wb.wen1     = ex.wen1;
    next_wb.woffset0 = ex.woffset0;
    next_wb.woffset1 = ex.woffset1;
    next_wb.vd       = ex.vd;
    next_wb.rd_wen   = ex.rd_wen;
    next_wb.rd_sel   = ex.rd_sel;
    next_wb.rd_data  = (ex.config_type != NOT_CFG) ? new_vl : ex.rd_data;
    next_wb.sew      = sew;
  end

  // Writeback latch, flush before stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb <= '0;
    end else if (flush_mem) begin
      wb <= '0;
    end else if (adv) begin
      wb <= next_wb;
    end
  end

  // A memory instruction leaves only with no cache request open
  assert property (@(posedge CLK) disable iff (!nRST)
    (adv && (ex.load || ex.store)) |-> !(ren || wen));

endmodule

`default_nettype wire

// ==== vmem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmem_subsystem
  import vmem_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  ex_mem_t ex,
  input  logic    stall_mem,
  input  logic    flush_mem,
  output mem_wb_t wb,
  output logic    busy_mem,
  output logic    exception_mem,
  output logic    csr_update,
  output word_t   vl,
  output word_t   vtype
);

  // Stage to cache request lines
  word_t     dmemaddr;
  word_t     dmemstore;
  word_t     dmemload;
  logic      ren;
  logic      wen;
  logic      dhit;
  byte_ena_t byte_ena;

  vmem_memory_stage stage0 (
    .CLK           (CLK),
    .nRST          (nRST),
    .ex            (ex),
    .stall_mem     (stall_mem),
    .flush_mem     (flush_mem),
    .dmemload      (dmemload),
    .dhit          (dhit),
    .dmemaddr      (dmemaddr),
    .dmemstore     (dmemstore),
    .ren           (ren),
    .wen           (wen),
    .byte_ena      (byte_ena),
    .wb            (wb),
    .busy_mem      (busy_mem),
    .exception_mem (exception_mem),
    .csr_update    (csr_update),
    .vl            (vl),
    .vtype         (vtype)
  );

  vmem_dcache_model dcache0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .addr     (dmemaddr),
    .wdata    (dmemstore),
    .ren      (ren),
    .wen      (wen),
    .byte_ena (byte_ena),
    .rdata    (dmemload),
    .dhit     (dhit)
  );

endmodule

`default_nettype wire

// ==== vmem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vmem_cfg.svh"

module vmem_tb
  import vmem_pkg::*;
();

  localparam int BUSY_TIMEOUT = 200;

  // Expected writeback view of one table entry
  typedef struct packed {
    word_t wdat0;
    word_t wdat1;
    word_t rd_data;
    logic  wen0;
    logic  wen1;
    logic  rd_wen;
    logic  exc;
    logic  csr;
    word_t vl;
  } expect_t;

  // Pipeline control applied with an entry
  typedef struct packed {
    logic stall;
    logic flush;
  } ctl_t;

  logic    CLK;
  logic    nRST;
  ex_mem_t ex;
  logic    stall_mem;
  logic    flush_mem;
  mem_wb_t wb;
  logic    busy_mem;
  logic    exception_mem;
  logic    csr_update;
  word_t   vl;
  word_t   vtype;

  // Stimulus table with one slot per entry in each queue
  string   tname[$];
  ex_mem_t tstim[$];
  ctl_t    tctl[$];
  expect_t texp[$];

  int      errors;
  logic    exc_seen;
  integer  seed;

  vmem_subsystem dut0 (
    .CLK           (CLK),
    .nRST          (nRST),
    .ex            (ex),
    .stall_mem     (stall_mem),
    .flush_mem     (flush_mem),
    .wb            (wb),
    .busy_mem      (busy_mem),
    .exception_mem (exception_mem),
    .csr_update    (csr_update),
    .vl            (vl),
    .vtype         (vtype)
  );

  // 20 ns clock
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Catch the one-cycle exception pulse
  always @(posedge CLK) begin
    if (nRST && exception_mem) begin
      exc_seen = 1'b1;
    end
  end

  task automatic check_value(input string test, input string field,
                             input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h, actual %h", test, field, exp, act);
      errors++;
    end
  endtask

  // Cache contents right after reset
  function automatic word_t preload(input int unsigned w);
    return 32'h1000_0000 + word_t'(w);
  endfunction

  // One byte of a word replaced
  function automatic word_t merge_byte(input word_t w, input int unsigned b,
                                       input logic [7:0] d);
    word_t r;
    r = w;
    r[b*8 +: 8] = d;
    return r;
  endfunction

  function automatic ex_mem_t alu_ex(input word_t r0, input word_t r1, input logic we,
                                     input logic rdw, input word_t rdd);
    ex_mem_t e;
    e            = '0;
    e.aluresult0 = r0;
    e.aluresult1 = r1;
    e.wen0       = we;
    e.wen1       = we;
    e.woffset1   = 8'd1;
    e.vd         = 5'd2;
    e.rd_wen     = rdw;
    e.rd_sel     = 5'd7;
    e.rd_data    = rdd;
    return e;
  endfunction

  // vsetvli or vsetvl with the new vl going to rd
  function automatic ex_mem_t cfg_ex(input cfg_t kind, input word_t vt, input word_t avl);
    ex_mem_t e;
    e             = '0;
    e.rd_wen      = 1'b1;
    e.rd_sel      = 5'd5;
    e.config_type = kind;
    e.next_vtype  = vt;
    e.next_avl    = avl;
    return e;
  endfunction

  // Two-lane load or store with lane addresses in the ALU results
  function automatic ex_mem_t mem_ex(input logic ld, input word_t a0, input word_t a1,
                                     input word_t d0, input word_t d1,
                                     input elem_idx_t woff1);
    ex_mem_t e;
    e            = '0;
    e.load       = ld;
    e.store      = !ld;
    e.aluresult0 = a0;
    e.aluresult1 = a1;
    e.storedata0 = d0;
    e.storedata1 = d1;
    e.wen0       = ld;
    e.wen1       = ld;
    e.woffset1   = woff1;
    e.vd         = 5'd3;
    return e;
  endfunction

  function automatic expect_t exp_wb(input word_t w0, input word_t w1, input word_t rdd,
                                     input logic we0, input logic we1, input logic rdw,
                                     input logic exc, input word_t vlen);
    expect_t x;
    x.wdat0   = w0;
    x.wdat1   = w1;
    x.rd_data = rdd;
    x.wen0    = we0;
    x.wen1    = we1;
    x.rd_wen  = rdw;
    x.exc     = exc;
    x.csr     = 1'b0;
    x.vl      = vlen;
    return x;
  endfunction

  // Config result with the clipped vl in rd and csr_update high
  function automatic expect_t exp_cfg(input word_t vlen);
    expect_t x;
    x     = exp_wb(0, 0, vlen, 0, 0, 1, 0, vlen);
    x.csr = 1'b1;
    return x;
  endfunction

  task automatic add_entry(input string name, input ex_mem_t e, input logic stall,
                           input logic flush, input expect_t x);
    ctl_t c;
    c.stall = stall;
    c.flush = flush;
    tname.push_back(name);
    tstim.push_back(e);
    tctl.push_back(c);
    texp.push_back(x);
  endtask

  task automatic build_table();
    int unsigned w[4];
    int unsigned b2;
    int unsigned b3;
    word_t       d0;
    word_t       d1;
    logic        clash;
    // Configuration clipped to VLMAX
    add_entry("cfg_sew32", cfg_ex(CFG_VSETVLI, 32'd2, 32'd12), 0, 0, exp_cfg(32'd8));
    // Plain result then stall hold and flush clear
    add_entry("alu_pass", alu_ex(32'hcafe_0001, 32'hcafe_0002, 1, 0, 32'h55), 0, 0,
              exp_wb(32'hcafe_0001, 32'hcafe_0002, 32'h55, 1, 1, 0, 0, 32'd8));
    add_entry("alu_stall", alu_ex(32'hdead_0001, 32'hdead_0002, 0, 1, 32'h66), 1, 0,
              exp_wb(32'hcafe_0001, 32'hcafe_0002, 32'h55, 1, 1, 0, 0, 32'd8));
    add_entry("alu_flush", alu_ex(32'h1111, 32'h2222, 1, 1, 32'h33), 0, 1,
              exp_wb(0, 0, 0, 0, 0, 0, 0, 32'd8));
    // Word loads with lane 1 active and gated
    add_entry("load_two_words", mem_ex(1, 32'd12, 32'd36, 0, 0, 8'd1), 0, 0,
              exp_wb(preload(3), preload(9), 0, 1, 1, 0, 0, 32'd8));
    add_entry("load_lane1_gated", mem_ex(1, 32'd16, 32'h50, 0, 0, 8'd8), 0, 0,
              exp_wb(preload(4), 32'h50, 0, 1, 1, 0, 0, 32'd8));
    // Byte loads under SEW8 with vl 4
    add_entry("cfg_sew8", cfg_ex(CFG_VSETVLI, 32'd0, 32'd4), 0, 0, exp_cfg(32'd4));
    add_entry("load_byte3", mem_ex(1, 32'd23, 32'h77, 0, 0, 8'd4), 0, 0,
              exp_wb(32'h10, 32'h77, 0, 1, 1, 0, 0, 32'd4));
    add_entry("load_byte0", mem_ex(1, 32'd20, 32'h77, 0, 0, 8'd4), 0, 0,
              exp_wb(32'h05, 32'h77, 0, 1, 1, 0, 0, 32'd4));
    // Misaligned word load keeps the last buffered lane 0 element
    add_entry("cfg_sew32_vl2", cfg_ex(CFG_VSETVL, 32'd2, 32'd2), 0, 0, exp_cfg(32'd2));
    add_entry("load_misaligned", mem_ex(1, 32'h12, 32'h20, 0, 0, 8'd1), 0, 0,
              exp_wb(32'h05, 32'h20, 0, 1, 1, 0, 1, 32'd2));
    // Four distinct random words for the store checks
    for (int k = 0; k < 4; k++) begin
      clash = 1'b1;
      while (clash) begin
        w[k]  = $unsigned($random(seed)) % `VMEM_DEPTH;
        clash = 1'b0;
        for (int j = 0; j < k; j++) begin
          if (w[j] == w[k]) begin
            clash = 1'b1;
          end
        end
      end
    end
    b2 = $unsigned($random(seed)) % 4;
    b3 = $unsigned($random(seed)) % 4;
    d0 = $random(seed);
    d1 = $random(seed);
    add_entry("store_words", mem_ex(0, w[0] * 4, w[1] * 4, d0, d1, 8'd1), 0, 0,
              exp_wb(w[0] * 4, w[1] * 4, 0, 0, 0, 0, 0, 32'd2));
    add_entry("load_words_back", mem_ex(1, w[0] * 4, w[1] * 4, 0, 0, 8'd1), 0, 0,
              exp_wb(d0, d1, 0, 1, 1, 0, 0, 32'd2));
    add_entry("cfg_sew8_vl8", cfg_ex(CFG_VSETVL, 32'd0, 32'd8), 0, 0, exp_cfg(32'd8));
    add_entry("store_bytes", mem_ex(0, w[2] * 4 + b2, w[3] * 4 + b3, 32'hab, 32'hcd, 8'd1),
              0, 0, exp_wb(w[2] * 4 + b2, w[3] * 4 + b3, 0, 0, 0, 0, 0, 32'd8));
    add_entry("cfg_sew32_vl8", cfg_ex(CFG_VSETVLI, 32'd2, 32'd8), 0, 0, exp_cfg(32'd8));
    add_entry("load_merged", mem_ex(1, w[2] * 4, w[3] * 4, 0, 0, 8'd1), 0, 0,
              exp_wb(merge_byte(preload(w[2]), b2, 8'hab),
                     merge_byte(preload(w[3]), b3, 8'hcd), 0, 1, 1, 0, 0, 32'd8));
  endtask

  // Poll at falling edges until the stage stops asking for more cycles
  task automatic wait_not_busy(input string test);
    int cycles;
    cycles = 0;
    while (busy_mem && cycles < BUSY_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (busy_mem) begin
      $display("timeout in %s: busy_mem still high after %0d cycles", test, BUSY_TIMEOUT);
      errors++;
    end
  endtask

  initial begin
    expect_t e;
    logic    exp_busy;
    errors    = 0;
    exc_seen  = 1'b0;
    seed      = 53;
    nRST      = 1'b0;
    ex        = '0;
    stall_mem = 1'b0;
    flush_mem = 1'b0;
    build_table();
    repeat (8) @(negedge CLK);
    // Idle outputs while reset is held
    check_value("reset", "wb_zero", 32'd1, word_t'(wb == '0));
    check_value("reset", "vl", 32'd0, vl);
    check_value("reset", "vtype", 32'd0, vtype);
    check_value("reset", "busy_mem", 32'd0, word_t'(busy_mem));
    nRST = 1'b1;
    for (int i = 0; i < tname.size(); i++) begin
      e         = texp[i];
      ex        = tstim[i];
      stall_mem = tctl[i].stall;
      flush_mem = tctl[i].flush;
      exc_seen  = 1'b0;
      @(negedge CLK);
      check_value(tname[i], "csr_update", word_t'(e.csr), word_t'(csr_update));
      // Aligned memory ops still in their lane walk here
      exp_busy = (ex.load || ex.store) && !e.exc;
      check_value(tname[i], "busy_mem", word_t'(exp_busy), word_t'(busy_mem));
      wait_not_busy(tname[i]);
      @(negedge CLK);
      check_value(tname[i], "wdat0", e.wdat0, wb.wdat0);
      check_value(tname[i], "wdat1", e.wdat1, wb.wdat1);
      check_value(tname[i], "rd_data", e.rd_data, wb.rd_data);
      check_value(tname[i], "wen0", word_t'(e.wen0), word_t'(wb.wen0));
      check_value(tname[i], "wen1", word_t'(e.wen1), word_t'(wb.wen1));
      check_value(tname[i], "rd_wen", word_t'(e.rd_wen), word_t'(wb.rd_wen));
      check_value(tname[i], "exception", word_t'(e.exc), word_t'(exc_seen));
      check_value(tname[i], "vl", e.vl, vl);
    end
    ex = '0;
    $display("%0d entries applied, %0d errors", tname.size(), errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vmem.f ====
+incdir+.
vmem_pkg.sv
vmem_addr_scheduler.sv
vmem_dcache_model.sv
vmem_csr_block.sv
vmem_memory_stage.sv
vmem_subsystem.sv
vmem_tb.sv
